// File: logic/usb_bus_pkg.sv
`default_nettype none

// sizing shared by every block on the register bus
package usb_bus_pkg;

  // usb chip data/address bus and register data
  localparam int bus_width = 8;           // one byte per bus cycle

  // byte index within a multi-byte register
  localparam int bytecnt_width = 7;       // free running, rolls over

  // sample fifo geometry
  localparam int fifo_depth = 16;         // entries, power of two
  localparam int fifo_ptr_width = 4;      // log2 of fifo_depth, wraps naturally
  localparam int fifo_count_width = 5;    // holds 0 .. fifo_depth

endpackage

`default_nettype wire

// File: logic/reg_map_pkg.sv
`default_nettype none

// host visible register map of the capture engine
package reg_map_pkg;

  // register addresses
  localparam logic [7:0] addr_id        = 8'h00; // read only id byte
  localparam logic [7:0] addr_scratch   = 8'h01; // 4 byte scratch, bytecnt indexed
  localparam logic [7:0] addr_ctrl      = 8'h02; // arm / flush control
  localparam logic [7:0] addr_status    = 8'h03; // fifo occupancy
  localparam logic [7:0] addr_fifo_data = 8'h04; // fifo drain port

  // fixed value returned from addr_id
  localparam logic [7:0] id_value = 8'h5A;

  // control byte bit positions
  localparam int ctrl_arm_bit   = 0;      // sample capture enable, sticky
  localparam int ctrl_flush_bit = 1;      // fifo flush, self clearing

endpackage

`default_nettype wire

// File: logic/usb_reg_front.sv
`default_nettype none
`timescale 1ns/10ps

module usb_reg_front (
  input  wire                                   clk_usb,
  input  wire                                   reset,

  // usb controller chip side
  input  wire  [usb_bus_pkg::bus_width-1:0]     cwusb_din,
  output logic [usb_bus_pkg::bus_width-1:0]     cwusb_dout,
  output logic                                  cwusb_isout,
  input  wire  [usb_bus_pkg::bus_width-1:0]     cwusb_addr,
  input  wire                                   cwusb_rdn,   // low active read strobe
  input  wire                                   cwusb_wrn,   // low active write strobe
  input  wire                                   cwusb_cen,   // low active chip enable
  input  wire                                   cwusb_alen,  // low active address latch

  // register bus side
  input  wire                                   fast_fifo_read, // fifo port selected
  input  wire  [usb_bus_pkg::bus_width-1:0]     reg_datai,   // read byte from selector
  output logic [usb_bus_pkg::bus_width-1:0]     reg_address,
  output logic [usb_bus_pkg::bytecnt_width-1:0] reg_bytecnt,
  output logic [usb_bus_pkg::bus_width-1:0]     reg_datao,
  output logic                                  reg_read,    // level, high while rdn low
  output logic                                  reg_write    // single cycle pulse
);

  logic wrn_rs;           // sampled wrn
  logic wrn_rs_dly;       // wrn one cycle older
  logic alen_r;           // sampled alen
  logic read_dly;         // reg_read one cycle older, gives isout tail
  logic write_dly;        // reg_write one cycle older, bumps bytecnt
  logic drive_data_out;   // bus held for fast fifo reads
  logic fast_fifo_read_r; // for rising edge detect

  // strobe sampling and write end detect
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wrn_rs     <= 1'b1;                     // strobes idle high
      wrn_rs_dly <= 1'b1;
      alen_r     <= 1'b1;
      reg_read   <= 1'b0;
      read_dly   <= 1'b0;
      reg_write  <= 1'b0;
      write_dly  <= 1'b0;
    end else begin
      wrn_rs     <= cwusb_wrn;
      wrn_rs_dly <= wrn_rs;
      alen_r     <= cwusb_alen;
      reg_read   <= ~cwusb_rdn;               // one cycle after rdn falls
      read_dly   <= reg_read;
      reg_write  <= wrn_rs & ~wrn_rs_dly;     // rising wrn = end of write
      write_dly  <= reg_write;
    end
  end

  // address and write data, payload only
  always_ff @(posedge clk_usb) begin
    reg_address <= cwusb_addr;                // one cycle behind the pins
    if (~cwusb_cen & ~wrn_rs)
      reg_datao <= cwusb_din;                 // keeps last byte of the strobe
  end

  // fast fifo reads keep the bus until the host starts a write
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      fast_fifo_read_r <= 1'b0;
      drive_data_out   <= 1'b0;
    end else begin
      fast_fifo_read_r <= fast_fifo_read;
      if (~wrn_rs)
        drive_data_out <= 1'b0;               // write seen, release bus
      else if (fast_fifo_read & ~fast_fifo_read_r)
        drive_data_out <= 1'b1;               // fifo port just selected
    end
  end

  // byte counter, clears on address phase, bumps after each access
  always_ff @(posedge clk_usb) begin
    if (reset)
      reg_bytecnt <= '0;
    else if (~alen_r)
      reg_bytecnt <= '0;
    else if ((read_dly & ~reg_read) | write_dly)
      reg_bytecnt <= reg_bytecnt + 1'b1;      // rollover allowed
  end

  assign cwusb_dout  = reg_datai;             // straight through, selector registers
  assign cwusb_isout = reg_read | read_dly | (drive_data_out & wrn_rs); // one cycle tail

endmodule

`default_nettype wire

// File: logic/ctrl_regs.sv
`default_nettype none
`timescale 1ns/10ps

module ctrl_regs (
  input  wire                                      clk_usb,
  input  wire                                      reset,
  input  wire  [usb_bus_pkg::bus_width-1:0]        reg_address,
  input  wire  [usb_bus_pkg::bytecnt_width-1:0]    reg_bytecnt,
  input  wire  [usb_bus_pkg::bus_width-1:0]        reg_datao,
  input  wire                                      reg_write,
  input  wire  [usb_bus_pkg::fifo_count_width-1:0] fifo_count, // from capture_fifo
  output logic [usb_bus_pkg::bus_width-1:0]        ctrl_datai, // registered read byte
  output logic                                     arm,        // capture enable level
  output logic                                     flush       // one cycle fifo clear
);

  import usb_bus_pkg::*;
  import reg_map_pkg::*;

  logic [bus_width-1:0] scratch [4];          // 4 byte scratch register
  logic [1:0]           byte_sel;             // bytecnt modulo 4
  logic [bus_width-1:0] ctrl_byte;            // control byte as read back
  logic [bus_width-1:0] status_byte;          // fifo_count zero extended

  assign byte_sel = reg_bytecnt[1:0];

  // flush always reads back as 0
  always_comb begin
    ctrl_byte               = '0;
    ctrl_byte[ctrl_arm_bit] = arm;
  end

  assign status_byte = {{(bus_width - fifo_count_width){1'b0}}, fifo_count};

  // scratch storage
  always_ff @(posedge clk_usb) begin
    if (reg_write && (reg_address == addr_scratch))
      scratch[byte_sel] <= reg_datao;         // one byte per write pulse
  end

  // arm is sticky, flush lasts one cycle
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      arm   <= 1'b0;
      flush <= 1'b0;
    end else begin
      flush <= 1'b0;
      if (reg_write && (reg_address == addr_ctrl)) begin
        arm   <= reg_datao[ctrl_arm_bit];
        flush <= reg_datao[ctrl_flush_bit];
      end
    end
  end

  // read byte, one cycle after address/bytecnt
  always_ff @(posedge clk_usb) begin
    case (reg_address)
      addr_id:      ctrl_datai <= id_value;
      addr_scratch: ctrl_datai <= scratch[byte_sel];
      addr_ctrl:    ctrl_datai <= ctrl_byte;
      addr_status:  ctrl_datai <= status_byte;
      default:      ctrl_datai <= '0;         // not ours, selector ignores it
    endcase
  end

endmodule

`default_nettype wire

// File: logic/capture_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module capture_fifo (
  input  wire                                      clk_usb,
  input  wire                                      reset,
  input  wire  [usb_bus_pkg::bus_width-1:0]        reg_address,
  input  wire                                      reg_read,
  input  wire                                      arm,          // capture enable
  input  wire                                      flush,        // empties the fifo
  input  wire  [usb_bus_pkg::bus_width-1:0]        sample_data,
  input  wire                                      sample_valid, // single cycle strobe
  output logic [usb_bus_pkg::bus_width-1:0]        fifo_datai,   // head byte, registered
  output logic [usb_bus_pkg::fifo_count_width-1:0] fifo_count,
  output logic                                     fast_fifo_read
);

  import usb_bus_pkg::*;
  import reg_map_pkg::*;

  logic [bus_width-1:0]        mem [fifo_depth]; // circular sample buffer
  logic [fifo_ptr_width-1:0]   wr_ptr;           // next free slot
  logic [fifo_ptr_width-1:0]   rd_ptr;           // head slot
  logic                        read_q;           // reg_read one cycle older
  logic                        empty;
  logic                        full;
  logic                        push;
  logic                        pop;

  assign empty = (fifo_count == '0);
  assign full  = (fifo_count == fifo_count_width'(fifo_depth));

  assign push = sample_valid & arm & ~full;   // full fifo drops the sample
  assign pop  = read_q & ~reg_read & (reg_address == addr_fifo_data) & ~empty; // read end

  // sample storage
  always_ff @(posedge clk_usb) begin
    if (push)
      mem[wr_ptr] <= sample_data;
  end

  // pointers and occupancy
  always_ff @(posedge clk_usb) begin
    if (reset | flush) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;              // depth is a power of two
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: fifo_count <= fifo_count;    // idle or both at once
      endcase
    end
  end

  // read end detect and fast read level
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      read_q         <= 1'b0;
      fast_fifo_read <= 1'b0;
    end else begin
      read_q         <= reg_read;
      fast_fifo_read <= (reg_address == addr_fifo_data);
    end
  end

  // head byte, 0x00 when empty
  always_ff @(posedge clk_usb) begin
    if (empty)
      fifo_datai <= '0;
    else
      fifo_datai <= mem[rd_ptr];              // next byte follows a pop
  end

endmodule

`default_nettype wire

// File: logic/reg_read_mux.sv
`default_nettype none
`timescale 1ns/10ps

module reg_read_mux (
  input  wire                               clk_usb,
  input  wire  [usb_bus_pkg::bus_width-1:0] reg_address,
  input  wire  [usb_bus_pkg::bus_width-1:0] ctrl_datai,  // from ctrl_regs
  input  wire  [usb_bus_pkg::bus_width-1:0] fifo_datai,  // from capture_fifo
  output logic [usb_bus_pkg::bus_width-1:0] reg_datai    // to front end
);

  import reg_map_pkg::*;

  logic sel_ctrl;                             // ctrl_regs owns the address
  logic sel_fifo;                             // capture_fifo owns the address

  // decode registered so it lines up with the registered peer bytes
  always_ff @(posedge clk_usb) begin
    sel_ctrl <= (reg_address == addr_id)      |
                (reg_address == addr_scratch) |
                (reg_address == addr_ctrl)    |
                (reg_address == addr_status);
    sel_fifo <= (reg_address == addr_fifo_data);
  end

  // pick owner byte
  always_comb begin
    if (sel_ctrl)
      reg_datai = ctrl_datai;
    else if (sel_fifo)
      reg_datai = fifo_datai;
    else
      reg_datai = '1;                         // unmapped reads 0xFF
  end

endmodule

`default_nettype wire

// File: logic/usb_capture_top.sv
`default_nettype none
`timescale 1ns/10ps

module usb_capture_top (
  input  wire                               clk_usb,
  input  wire                               reset,
  input  wire  [usb_bus_pkg::bus_width-1:0] cwusb_din,
  output wire  [usb_bus_pkg::bus_width-1:0] cwusb_dout,
  output wire                               cwusb_isout,
  input  wire  [usb_bus_pkg::bus_width-1:0] cwusb_addr,
  input  wire                               cwusb_rdn,
  input  wire                               cwusb_wrn,
  input  wire                               cwusb_cen,
  input  wire                               cwusb_alen,
  input  wire  [usb_bus_pkg::bus_width-1:0] sample_data,   // capture source, clk_usb
  input  wire                               sample_valid
);

  import usb_bus_pkg::*;

  // register bus, front end is sole driver
  wire [bus_width-1:0]        reg_address;
  wire [bytecnt_width-1:0]    reg_bytecnt;
  wire [bus_width-1:0]        reg_datao;
  wire [bus_width-1:0]        reg_datai;
  wire                        reg_read;
  wire                        reg_write;

  // peer read bytes and side signals
  wire [bus_width-1:0]        ctrl_datai;
  wire [bus_width-1:0]        fifo_datai;
  wire [fifo_count_width-1:0] fifo_count;     // status back to ctrl_regs
  wire                        fast_fifo_read;
  wire                        arm;
  wire                        flush;

  usb_reg_front i_front (
    .clk_usb(clk_usb), .reset(reset),
    .cwusb_din(cwusb_din), .cwusb_dout(cwusb_dout), .cwusb_isout(cwusb_isout),
    .cwusb_addr(cwusb_addr), .cwusb_rdn(cwusb_rdn), .cwusb_wrn(cwusb_wrn),
    .cwusb_cen(cwusb_cen), .cwusb_alen(cwusb_alen),
    .fast_fifo_read(fast_fifo_read), .reg_datai(reg_datai),
    .reg_address(reg_address), .reg_bytecnt(reg_bytecnt), .reg_datao(reg_datao),
    .reg_read(reg_read), .reg_write(reg_write)
  );

  ctrl_regs i_ctrl (
    .clk_usb(clk_usb), .reset(reset),
    .reg_address(reg_address), .reg_bytecnt(reg_bytecnt), .reg_datao(reg_datao),
    .reg_write(reg_write), .fifo_count(fifo_count),
    .ctrl_datai(ctrl_datai), .arm(arm), .flush(flush)
  );

  capture_fifo i_fifo (
    .clk_usb(clk_usb), .reset(reset),
    .reg_address(reg_address), .reg_read(reg_read), .arm(arm), .flush(flush),
    .sample_data(sample_data), .sample_valid(sample_valid),
    .fifo_datai(fifo_datai), .fifo_count(fifo_count), .fast_fifo_read(fast_fifo_read)
  );

  reg_read_mux i_mux (
    .clk_usb(clk_usb), .reg_address(reg_address),
    .ctrl_datai(ctrl_datai), .fifo_datai(fifo_datai), .reg_datai(reg_datai)
  );

endmodule

`default_nettype wire

// File: verification/tb_checker.sv
`default_nettype none
`timescale 1ns/10ps

module tb_checker (
  input  wire        clk_usb,
  input  wire [7:0]  cwusb_dout,   // watched dut outputs
  input  wire        cwusb_isout,
  input  wire        cmp_dout,     // compare strobes from the bench
  input  wire [7:0]  exp_dout,
  input  wire        cmp_isout,
  input  wire        exp_isout,
  input  wire        test_end,     // closes the current test
  input  wire [31:0] test_num,
  output integer     check_count,
  output integer     error_count,
  output integer     test_count
);

  integer test_checks;             // per test tallies
  integer test_errors;

  initial begin
    check_count = 0;
    error_count = 0;
    test_count  = 0;
    test_checks = 0;
    test_errors = 0;
  end

  // outputs sampled on the edge after the strobe, values settled by then
  always @(posedge clk_usb) begin : compare
    integer new_checks;
    integer new_errors;
    new_checks = 0;
    new_errors = 0;
    if (cmp_dout) begin
      new_checks = new_checks + 1;
      if (cwusb_dout !== exp_dout) begin
        $display("FAILED cwusb_dout in test %0d: expected %h, got %h",
                 test_num, exp_dout, cwusb_dout);
        new_errors = new_errors + 1;
      end
    end
    if (cmp_isout) begin
      new_checks = new_checks + 1;
      if (cwusb_isout !== exp_isout) begin
        $display("FAILED cwusb_isout in test %0d: expected %h, got %h",
                 test_num, exp_isout, cwusb_isout);
        new_errors = new_errors + 1;
      end
    end
    check_count <= check_count + new_checks;
    error_count <= error_count + new_errors;
    if (test_end) begin
      $display("test %0d done: %0d checks, %0d errors", test_num, test_checks, test_errors);
      test_count  <= test_count + 1;
      test_checks <= 0;
      test_errors <= 0;
    end else begin
      test_checks <= test_checks + new_checks;
      test_errors <= test_errors + new_errors;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_usb_capture.sv
`default_nettype none
`timescale 1ns/10ps

module tb_usb_capture;

  import usb_bus_pkg::*;
  import reg_map_pkg::*;

  logic                 clk_usb;
  logic                 reset;
  logic [bus_width-1:0] cwusb_din, cwusb_addr, sample_data;
  logic                 cwusb_rdn, cwusb_wrn, cwusb_cen, cwusb_alen, sample_valid;
  wire  [bus_width-1:0] cwusb_dout;
  wire                  cwusb_isout;
  logic [bus_width-1:0] exp_dout;              // to the checker
  logic                 cmp_dout, cmp_isout, exp_isout, test_end;
  logic [31:0]          test_num;
  wire  [31:0]          check_count, error_count, test_count;
  logic [bus_width-1:0] model_q [$];           // expected fifo contents in push order
  logic                 model_arm;             // arm bit as last written
  logic                 bus_held;              // bus enable kept by a fifo port select
  integer               seed, fd, rc, issued;  // issued = compares handed to checker
  logic                 timed_out, file_bad, cases_done;
  logic [63:0]          op_word;               // operation token of a case line
  logic [8*120-1:0]     skip_line;

  always #50 clk_usb = ~clk_usb;               // 100 ns period

  usb_capture_top i_dut (
    .clk_usb(clk_usb), .reset(reset),
    .cwusb_din(cwusb_din), .cwusb_dout(cwusb_dout), .cwusb_isout(cwusb_isout),
    .cwusb_addr(cwusb_addr), .cwusb_rdn(cwusb_rdn), .cwusb_wrn(cwusb_wrn),
    .cwusb_cen(cwusb_cen), .cwusb_alen(cwusb_alen),
    .sample_data(sample_data), .sample_valid(sample_valid)
  );

  tb_checker i_checker (
    .clk_usb(clk_usb), .cwusb_dout(cwusb_dout), .cwusb_isout(cwusb_isout),
    .cmp_dout(cmp_dout), .exp_dout(exp_dout), .cmp_isout(cmp_isout), .exp_isout(exp_isout),
    .test_end(test_end), .test_num(test_num),
    .check_count(check_count), .error_count(error_count), .test_count(test_count)
  );

  // alen low with the address, bytecnt clears
  task set_address(input logic [bus_width-1:0] addr);
    begin
      if (addr == addr_fifo_data && cwusb_addr != addr_fifo_data)
        bus_held = 1'b1;                       // fifo port newly selected
      @(posedge clk_usb);
      cwusb_alen <= 1'b0;
      cwusb_addr <= addr;
      repeat (2) @(posedge clk_usb);
      cwusb_alen <= 1'b1;
      repeat (2) @(posedge clk_usb);           // clear settles
    end
  endtask

  task write_byte(input logic [bus_width-1:0] value);
    begin
      bus_held = 1'b0;                         // write strobe releases the bus
      @(posedge clk_usb);
      cwusb_din <= value;
      cwusb_cen <= 1'b0;
      cwusb_wrn <= 1'b0;
      repeat (2) @(posedge clk_usb);
      cwusb_wrn <= 1'b1;                       // end of write, pulse follows
      repeat (4) @(posedge clk_usb);           // din and cen held past the pulse
      cwusb_cen <= 1'b1;
    end
  endtask

  // rdn low 4 cycles, compare on the third, then the enable tail and hold
  task read_byte(input logic [bus_width-1:0] expected);
    begin
      @(posedge clk_usb);
      cwusb_rdn <= 1'b0;
      repeat (2) @(posedge clk_usb);
      exp_dout  <= expected;
      exp_isout <= 1'b1;
      cmp_dout  <= 1'b1;
      cmp_isout <= 1'b1;
      issued     = issued + 2;
      @(posedge clk_usb);
      cmp_dout  <= 1'b0;
      cmp_isout <= 1'b0;
      @(posedge clk_usb);
      cwusb_rdn <= 1'b1;
      @(posedge clk_usb);
      cmp_isout <= 1'b1;                       // one cycle tail after the read level
      issued     = issued + 1;
      @(posedge clk_usb);
      exp_isout <= bus_held;                   // low unless a fifo select holds the bus
      issued     = issued + 1;
      @(posedge clk_usb);
      cmp_isout <= 1'b0;
    end
  endtask

  task push_sample;
    logic [bus_width-1:0] value;
    begin
      value = $random(seed);
      if (model_arm && model_q.size() < fifo_depth)
        model_q.push_back(value);              // full or disarmed drops it
      @(posedge clk_usb);
      sample_data  <= value;
      sample_valid <= 1'b1;
      @(posedge clk_usb);
      sample_valid <= 1'b0;
    end
  endtask

  // wait for the checker to catch up, then close the test
  task finish_test;
    integer waited;
    begin
      waited = 0;
      while (check_count < issued && waited < 40) begin
        @(posedge clk_usb);
        waited = waited + 1;
      end
      if (check_count < issued) begin
        $display("timeout: checker saw only %0d of %0d compares", check_count, issued);
        timed_out = 1'b1;
      end
      @(posedge clk_usb);
      test_end <= 1'b1;
      @(posedge clk_usb);
      test_end <= 1'b0;
    end
  endtask

  task run_case;
    logic [bus_width-1:0] addr;
    logic [bus_width-1:0] value;
    integer               count;
    integer               i;
    integer               got;
    begin
      if (op_word == "#") begin
        got = $fgets(skip_line, fd);           // comment line
      end else begin
        got = $fscanf(fd, "%h %d", addr, count);
        if (got != 2) begin
          $display("address or byte count missing in the cases file, stopping");
          file_bad   = 1'b1;
          cases_done = 1'b1;
        end else if (op_word == "write") begin
          set_address(addr);
          for (i = 0; i < count; i = i + 1) begin
            got = $fscanf(fd, "%h", value);
            if (got != 1) begin
              $display("data byte missing in the cases file");
              file_bad = 1'b1;
            end
            if (addr == addr_ctrl) begin
              model_arm = value[ctrl_arm_bit];
              if (value[ctrl_flush_bit])
                model_q.delete();              // flush empties the fifo
            end
            write_byte(value);
          end
        end else if (op_word == "read") begin
          test_num <= test_num + 1;
          set_address(addr);
          for (i = 0; i < count; i = i + 1) begin
            if (addr == addr_fifo_data) begin
              if (model_q.size() > 0)
                value = model_q.pop_front();
              else
                value = '0;                    // empty fifo reads 0x00
              read_byte(value);
            end else begin
              got = $fscanf(fd, "%h", value);
              if (got != 1) begin
                $display("expected byte missing in the cases file");
                file_bad = 1'b1;
              end
              read_byte(value);
            end
          end
          finish_test;
        end else if (op_word == "sample") begin
          for (i = 0; i < count; i = i + 1)
            push_sample;
        end else if (op_word == "wait") begin
          repeat (count) @(posedge clk_usb);
        end else begin
          $display("unknown operation in the cases file, stopping");
          file_bad   = 1'b1;
          cases_done = 1'b1;
        end
      end
    end
  endtask

  initial begin
    clk_usb      = 1'b0;
    reset        = 1'b1;
    cwusb_din    = '0;
    cwusb_addr   = '0;
    cwusb_rdn    = 1'b1;                       // strobes idle high
    cwusb_wrn    = 1'b1;
    cwusb_cen    = 1'b1;
    cwusb_alen   = 1'b1;
    sample_data  = '0;
    sample_valid = 1'b0;
    exp_dout     = '0;
    cmp_dout     = 1'b0;
    cmp_isout    = 1'b0;
    exp_isout    = 1'b0;
    test_end     = 1'b0;
    test_num     = 1;
    model_arm    = 1'b0;
    bus_held     = 1'b0;
    seed         = 34;
    issued       = 0;
    timed_out    = 1'b0;
    file_bad     = 1'b0;
    cases_done   = 1'b0;
    repeat (3) @(posedge clk_usb);
    reset <= 1'b0;
    repeat (2) @(posedge clk_usb);
    exp_isout <= 1'b0;                         // bus released after reset
    cmp_isout <= 1'b1;
    issued     = issued + 1;
    @(posedge clk_usb);
    cmp_isout <= 1'b0;
    finish_test;
    fd = $fopen("verification/usb_capture_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open verification/usb_capture_cases.txt");
      file_bad = 1'b1;
    end else begin
      while (!cases_done && !timed_out) begin
        rc = $fscanf(fd, "%s", op_word);
        if (rc != 1)
          cases_done = 1'b1;                   // end of file
        else
          run_case;
      end
      $fclose(fd);
    end
    @(posedge clk_usb);
    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (timed_out || file_bad || error_count != 0 || check_count != issued)
      $display("Test failed");
    else
      $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/usb_capture_cases.txt
# columns: operation, address (hex), byte count, then data or expected bytes (hex)
# reads at address 04 and sample lines take their bytes from the bench model
read   00 1 5a
write  01 4 11 22 33 44
read   01 4 11 22 33 44
read   07 1 ff
sample 00 3
read   03 1 00
write  02 1 01
sample 00 5
read   03 1 05
read   04 5
read   04 1
read   03 1 00
sample 00 20
read   03 1 10
read   04 16
read   04 1
sample 00 3
read   03 1 03
write  02 1 03
read   03 1 00
read   04 1
read   02 1 01
sample 00 1
read   03 1 01
read   04 1
wait   00 4

// File: files.f
logic/usb_bus_pkg.sv
logic/reg_map_pkg.sv
logic/usb_reg_front.sv
logic/ctrl_regs.sv
logic/capture_fifo.sv
logic/reg_read_mux.sv
logic/usb_capture_top.sv
verification/tb_checker.sv
verification/tb_usb_capture.sv
